// File: source/hdd_pkg.sv
package hdd_pkg;

    // ------------------------------------------------------------
    // Device-select offsets and ProDOS codes
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        OFF_EXEC      = 4'h0,    // Execute and return status
        OFF_STATUS    = 4'h1,
        OFF_COMMAND   = 4'h2,
        OFF_UNIT      = 4'h3,
        OFF_MEM_L     = 4'h4,
        OFF_MEM_H     = 4'h5,
        OFF_BLK_L     = 4'h6,
        OFF_BLK_H     = 4'h7,
        OFF_NEXT_BYTE = 4'h8     // Sector buffer data port
    } reg_off_e;

    typedef enum logic [7:0] {
        CMD_STATUS = 8'h00,
        CMD_READ   = 8'h01,
        CMD_WRITE  = 8'h02,
        CMD_FORMAT = 8'h03
    } cmd_e;

    localparam logic [7:0] STATUS_NO_DEVICE = 8'h28;
    localparam logic [7:0] STATUS_PROTECT   = 8'h2B;

    // ------------------------------------------------------------
    // Bus and register bundles
    // ------------------------------------------------------------
    typedef struct packed {
        logic       sel;         // Device select
        logic       rd;          // 6502 read, low for write
        logic [3:0] addr;
        logic [7:0] data;        // Write data from the CPU
    } bus_req_t;

    typedef struct packed {
        logic       reg_wr;
        logic       reg_rd;
        logic       exec;
        logic       buf_rd;
        logic       buf_wr;
        logic [3:0] offset;
        logic [7:0] wdata;
    } bus_op_t;

    typedef struct packed {
        logic       err;
        logic [7:0] code;        // Value returned on the execute read
    } exec_result_t;

    typedef struct packed {
        logic [7:0] status;
        logic [7:0] command;
        logic [7:0] unit;
        logic [7:0] mem_l;
        logic [7:0] mem_h;
        logic [7:0] blk_l;
        logic [7:0] blk_h;
    } hdd_regs_t;

endpackage

// File: source/hdd_bus_fsm.sv
module hdd_bus_fsm (
    input  logic                  CLK_14M,
    input  logic                  RESET,
    input  logic                  phi0,
    input  hdd_pkg::bus_req_t     bus,
    input  logic                  hdd_mounted,
    input  logic                  hdd_protect,
    input  logic [7:0]            command,
    output hdd_pkg::bus_op_t      op,
    output hdd_pkg::exec_result_t exec_res,
    output logic                  cnt_clear,
    output logic                  cnt_step,
    output logic                  hdd_read,
    output logic                  hdd_write
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_RELEASE
    } state_t;

    state_t                state;
    logic                  is_next;      // Current access targets next_byte
    logic                  start;
    hdd_pkg::bus_op_t      op_dec;
    hdd_pkg::exec_result_t res_dec;
    logic                  rd_ok;
    logic                  wr_ok;
    logic                  clr_dec;

    assign start    = phi0 && bus.sel && (state == ST_IDLE);
    assign cnt_step = (state == ST_RELEASE) && is_next;

    // ------------------------------------------------------------
    // Offset decode and command evaluation
    // ------------------------------------------------------------
    always_comb
    begin
        op_dec        = '0;
        op_dec.offset = bus.addr;
        op_dec.wdata  = bus.data;
        case (bus.addr)
            hdd_pkg::OFF_EXEC:      op_dec.exec = bus.rd;   // Writes here are ignored
            hdd_pkg::OFF_NEXT_BYTE:
            begin
                op_dec.buf_rd = bus.rd;
                op_dec.buf_wr = !bus.rd;
            end
            hdd_pkg::OFF_STATUS, hdd_pkg::OFF_COMMAND, hdd_pkg::OFF_UNIT,
            hdd_pkg::OFF_MEM_L, hdd_pkg::OFF_MEM_H, hdd_pkg::OFF_BLK_L,
            hdd_pkg::OFF_BLK_H:
            begin
                op_dec.reg_rd = bus.rd;
                op_dec.reg_wr = !bus.rd;
            end
            default: ;
        endcase

        res_dec = '0;
        rd_ok   = 1'b0;
        wr_ok   = 1'b0;
        case (command)
            hdd_pkg::CMD_READ:
            begin
                if (!hdd_mounted)
                    res_dec = '{err: 1'b1, code: hdd_pkg::STATUS_NO_DEVICE};
                else
                    rd_ok = 1'b1;
            end
            hdd_pkg::CMD_WRITE:
            begin
                if (!hdd_mounted)
                    res_dec = '{err: 1'b1, code: hdd_pkg::STATUS_NO_DEVICE};
                else if (hdd_protect)
                    res_dec = '{err: 1'b1, code: hdd_pkg::STATUS_PROTECT};
                else
                    wr_ok = 1'b1;
            end
            hdd_pkg::CMD_STATUS, hdd_pkg::CMD_FORMAT: ;  // Always succeed
            default: ;
        endcase

        // Offset restarts on execute and on a write-command setup
        clr_dec = op_dec.exec ||
                  (op_dec.reg_wr && (bus.addr == hdd_pkg::OFF_COMMAND) &&
                   (bus.data == hdd_pkg::CMD_WRITE));
    end

    // ------------------------------------------------------------
    // Access tracking and one-cycle strobes
    // ------------------------------------------------------------
    always_ff @(posedge CLK_14M)
    begin
        if (RESET)
        begin
            state     <= ST_IDLE;
            is_next   <= 1'b0;
            op        <= '0;
            exec_res  <= '0;
            cnt_clear <= 1'b0;
            hdd_read  <= 1'b0;
            hdd_write <= 1'b0;
        end
        else
        begin
            op        <= start ? op_dec : '0;
            cnt_clear <= start && clr_dec;
            hdd_read  <= start && op_dec.exec && rd_ok;
            hdd_write <= start && op_dec.exec && wr_ok;
            if (start)
                exec_res <= res_dec;

            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        state   <= ST_ACTIVE;
                        is_next <= (bus.addr == hdd_pkg::OFF_NEXT_BYTE);
                    end
                end
                ST_ACTIVE:
                begin
                    if (phi0 && !bus.sel)
                        state <= ST_RELEASE;    // End of access
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: source/hdd_sec_counter.sv
module hdd_sec_counter #(
    parameter int BUF_AW = 9
) (
    input  logic              CLK_14M,
    input  logic              RESET,
    input  logic              cnt_clear,
    input  logic              cnt_step,
    output logic [BUF_AW-1:0] sec_addr
);

    // ------------------------------------------------------------
    // Byte offset into the sector buffer
    // ------------------------------------------------------------
    always_ff @(posedge CLK_14M)
    begin
        if (RESET)
        begin
            sec_addr <= '0;
        end
        else if (cnt_clear)
        begin
            // Clear wins over a pending step
            sec_addr <= '0;
        end
        else if (cnt_step)
        begin
            sec_addr <= sec_addr + 1'b1;    // Wraps at end of sector
        end
    end

endmodule

// File: source/hdd_sector_buf.sv
module hdd_sector_buf #(
    parameter int BUF_AW = 9
) (
    input  logic              CLK_14M,
    // Host side
    input  logic [BUF_AW-1:0] ram_addr,
    input  logic [7:0]        ram_di,
    input  logic              ram_we,
    output logic [7:0]        ram_do,
    // CPU side
    input  logic [BUF_AW-1:0] sec_addr,
    input  hdd_pkg::bus_op_t  op,
    output logic [7:0]        cpu_rdata
);

    localparam int DEPTH = 2 ** BUF_AW;

    logic [7:0] mem [DEPTH];

    // ------------------------------------------------------------
    // Two ports, registered reads on both
    // ------------------------------------------------------------
    always_ff @(posedge CLK_14M)
    begin
        if (ram_we)
            mem[ram_addr] <= ram_di;
        ram_do <= mem[ram_addr];

        // CPU next-byte write lands at the current offset
        if (op.buf_wr)
            mem[sec_addr] <= op.wdata;
        cpu_rdata <= mem[sec_addr];
    end

endmodule

// File: source/hdd_regs.sv
module hdd_regs (
    input  logic                  CLK_14M,
    input  logic                  RESET,
    input  hdd_pkg::bus_op_t      op,
    input  hdd_pkg::exec_result_t exec_res,
    input  logic [7:0]            cpu_rdata,
    output hdd_pkg::hdd_regs_t    regs,
    output logic [7:0]            d_out
);

    logic [7:0] reg_rdata;

    // ------------------------------------------------------------
    // Register read select
    // ------------------------------------------------------------
    always_comb
    begin
        case (op.offset)
            hdd_pkg::OFF_STATUS:  reg_rdata = regs.status;
            hdd_pkg::OFF_COMMAND: reg_rdata = regs.command;
            hdd_pkg::OFF_UNIT:    reg_rdata = regs.unit;
            hdd_pkg::OFF_MEM_L:   reg_rdata = regs.mem_l;
            hdd_pkg::OFF_MEM_H:   reg_rdata = regs.mem_h;
            hdd_pkg::OFF_BLK_L:   reg_rdata = regs.blk_l;
            hdd_pkg::OFF_BLK_H:   reg_rdata = regs.blk_h;
            default:              reg_rdata = 8'hFF;
        endcase
    end

    // ------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------
    always_ff @(posedge CLK_14M)
    begin
        if (RESET)
        begin
            regs <= '0;
        end
        else
        begin
            if (op.reg_wr)
            begin
                case (op.offset)
                    // Status writable for ROR-style read-modify-write
                    hdd_pkg::OFF_STATUS:  regs.status  <= op.wdata;
                    hdd_pkg::OFF_COMMAND: regs.command <= op.wdata;
                    hdd_pkg::OFF_UNIT:    regs.unit    <= op.wdata;
                    hdd_pkg::OFF_MEM_L:   regs.mem_l   <= op.wdata;
                    hdd_pkg::OFF_MEM_H:   regs.mem_h   <= op.wdata;
                    hdd_pkg::OFF_BLK_L:   regs.blk_l   <= op.wdata;
                    hdd_pkg::OFF_BLK_H:   regs.blk_h   <= op.wdata;
                    default: ;
                endcase
            end
            if (op.exec)
                regs.status <= {7'b0, exec_res.err};    // Error flag in bit 0
        end
    end

    // ------------------------------------------------------------
    // CPU read data, held until the next read
    // ------------------------------------------------------------
    always_ff @(posedge CLK_14M)
    begin
        if (RESET)
        begin
            d_out <= 8'hFF;
        end
        else if (op.exec)
        begin
            d_out <= exec_res.code;
        end
        else if (op.reg_rd)
        begin
            d_out <= reg_rdata;
        end
        else if (op.buf_rd)
        begin
            d_out <= cpu_rdata;     // Byte at the current offset
        end
    end

endmodule

// File: source/hdd_card.sv
module hdd_card #(
    parameter int BUF_AW = 9
) (
    input  logic              CLK_14M,
    input  logic              RESET,
    input  logic              phi0,
    input  hdd_pkg::bus_req_t bus,
    input  logic              hdd_mounted,
    input  logic              hdd_protect,
    input  logic [BUF_AW-1:0] ram_addr,
    input  logic [7:0]        ram_di,
    input  logic              ram_we,
    output logic [7:0]        d_out,
    output logic [15:0]       sector,
    output logic              hdd_read,
    output logic              hdd_write,
    output logic [7:0]        ram_do
);

    hdd_pkg::bus_op_t      op;
    hdd_pkg::exec_result_t exec_res;
    hdd_pkg::hdd_regs_t    regs;
    logic                  cnt_clear;
    logic                  cnt_step;
    logic [BUF_AW-1:0]     sec_addr;
    logic [7:0]            cpu_rdata;

    assign sector = {regs.blk_h, regs.blk_l};   // Block number to the host

    // ------------------------------------------------------------
    // Bus decode and control
    // ------------------------------------------------------------
    hdd_bus_fsm u_bus_fsm (
        .CLK_14M     (CLK_14M),
        .RESET       (RESET),
        .phi0        (phi0),
        .bus         (bus),
        .hdd_mounted (hdd_mounted),
        .hdd_protect (hdd_protect),
        .command     (regs.command),
        .op          (op),
        .exec_res    (exec_res),
        .cnt_clear   (cnt_clear),
        .cnt_step    (cnt_step),
        .hdd_read    (hdd_read),
        .hdd_write   (hdd_write)
    );

    hdd_sec_counter #(.BUF_AW(BUF_AW)) u_sec_counter (
        .CLK_14M   (CLK_14M),
        .RESET     (RESET),
        .cnt_clear (cnt_clear),
        .cnt_step  (cnt_step),
        .sec_addr  (sec_addr)
    );

    // ------------------------------------------------------------
    // Sector storage and CPU-visible registers
    // ------------------------------------------------------------
    hdd_sector_buf #(.BUF_AW(BUF_AW)) u_sector_buf (
        .CLK_14M   (CLK_14M),
        .ram_addr  (ram_addr),
        .ram_di    (ram_di),
        .ram_we    (ram_we),
        .ram_do    (ram_do),
        .sec_addr  (sec_addr),
        .op        (op),
        .cpu_rdata (cpu_rdata)
    );

    hdd_regs u_regs (
        .CLK_14M   (CLK_14M),
        .RESET     (RESET),
        .op        (op),
        .exec_res  (exec_res),
        .cpu_rdata (cpu_rdata),
        .regs      (regs),
        .d_out     (d_out)
    );

endmodule

// File: test/hdd_card_assert.sv
module hdd_card_assert (
    input logic             CLK_14M,
    input logic             RESET,
    input hdd_pkg::bus_op_t op,
    input logic             cnt_clear,
    input logic             cnt_step,
    input logic             hdd_read,
    input logic             hdd_write
);

    int unsigned fails = 0;     // Failed assertions so far
    logic [4:0]  strobes;

    assign strobes = {op.reg_wr, op.reg_rd, op.exec, op.buf_rd, op.buf_wr};

    // ------------------------------------------------------------
    // Host strobes
    // ------------------------------------------------------------
    rd_wr_apart: assert property (@(posedge CLK_14M) disable iff (RESET)
        !(hdd_read && hdd_write))
    else
    begin
        fails++;
        $error("hdd_read and hdd_write high in the same cycle");
    end

    rd_one_cycle: assert property (@(posedge CLK_14M) disable iff (RESET)
        hdd_read |=> !hdd_read)
    else
    begin
        fails++;
        $error("hdd_read held longer than one cycle");
    end

    wr_one_cycle: assert property (@(posedge CLK_14M) disable iff (RESET)
        hdd_write |=> !hdd_write)
    else
    begin
        fails++;
        $error("hdd_write held longer than one cycle");
    end

    // Decoded op strobes
    op_one_cycle: assert property (@(posedge CLK_14M) disable iff (RESET)
        (|strobes) |=> !(|strobes))
    else
    begin
        fails++;
        $error("op strobe held longer than one cycle");
    end

    after_reset: assert property (@(posedge CLK_14M)
        RESET |=> (strobes == '0) && !hdd_read && !hdd_write && !cnt_clear && !cnt_step)
    else
    begin
        fails++;
        $error("strobe high on the cycle after reset");
    end

endmodule

bind hdd_bus_fsm hdd_card_assert u_assert (
    .CLK_14M   (CLK_14M),
    .RESET     (RESET),
    .op        (op),
    .cnt_clear (cnt_clear),
    .cnt_step  (cnt_step),
    .hdd_read  (hdd_read),
    .hdd_write (hdd_write)
);

// File: test/hdd_card_tb.sv
module hdd_card_tb;

    localparam int BUF_AW    = 9;
    localparam int COLS      = 6;       // Words per data file line
    localparam int MAX_TESTS = 128;

    // Op codes of the data file
    localparam logic [15:0] OP_CPU_WR    = 16'h0;
    localparam logic [15:0] OP_CPU_RD    = 16'h1;
    localparam logic [15:0] OP_EXEC      = 16'h2;
    localparam logic [15:0] OP_HOST_LOAD = 16'h3;
    localparam logic [15:0] OP_HOST_RD   = 16'h4;
    localparam logic [15:0] OP_RESET     = 16'h5;
    localparam logic [15:0] OP_SECTOR    = 16'h6;

    localparam hdd_pkg::bus_req_t BUS_IDLE = '{sel: 1'b0, rd: 1'b1, addr: 4'h0, data: 8'h00};

    logic              CLK_14M;
    logic              RESET;
    logic              phi0;
    hdd_pkg::bus_req_t bus;
    logic              hdd_mounted;
    logic              hdd_protect;
    logic [BUF_AW-1:0] ram_addr;
    logic [7:0]        ram_di;
    logic              ram_we;
    logic [7:0]        d_out;
    logic [15:0]       sector;
    logic              hdd_read;
    logic              hdd_write;
    logic [7:0]        ram_do;

    logic [15:0] tdata [0:COLS*MAX_TESTS-1];
    int          n_tests    = 0;
    bit          loaded     = 1'b0;
    int          pass_count = 0;
    int          err_count  = 0;
    bit          test_ok;
    int          rd_pulses  = 0;
    int          wr_pulses  = 0;

    hdd_card #(.BUF_AW(BUF_AW)) u_hdd_card (
        .CLK_14M     (CLK_14M),
        .RESET       (RESET),
        .phi0        (phi0),
        .bus         (bus),
        .hdd_mounted (hdd_mounted),
        .hdd_protect (hdd_protect),
        .ram_addr    (ram_addr),
        .ram_di      (ram_di),
        .ram_we      (ram_we),
        .d_out       (d_out),
        .sector      (sector),
        .hdd_read    (hdd_read),
        .hdd_write   (hdd_write),
        .ram_do      (ram_do)
    );

    // ------------------------------------------------------------
    // Clock, phi0 and strobe counting
    // ------------------------------------------------------------
    initial
    begin
        CLK_14M = 1'b0;
        forever
        begin
            #50 CLK_14M = ~CLK_14M;
        end
    end

    initial
    begin
        phi0 = 1'b0;
        forever
        begin
            @(posedge CLK_14M);
            #10 phi0 = ~phi0;   // High on every other edge
        end
    end

    always @(negedge CLK_14M)
    begin
        if (hdd_read === 1'b1)
            rd_pulses++;
        if (hdd_write === 1'b1)
            wr_pulses++;
    end

    // Watchdog sized from the number of data lines
    initial
    begin
        wait (loaded);
        repeat (n_tests * 12 + 20) @(posedge CLK_14M);
        $display("watchdog: tests did not finish within %0d clock periods", n_tests * 12 + 20);
        $display("=== FAIL ===");
        $finish;
    end

    // ------------------------------------------------------------
    // Drive and compare helpers
    // ------------------------------------------------------------
    task automatic next_drive_point();
        @(posedge CLK_14M);
        #10;
    endtask

    task automatic cpu_access(input logic rd, input logic [3:0] offset, input logic [7:0] data);
        bus = '{sel: 1'b1, rd: rd, addr: offset, data: data};
        repeat (4) next_drive_point();     // Two counted samples with sel high
        bus.sel = 1'b0;
        repeat (6) next_drive_point();     // Release, step and idle gap
        @(negedge CLK_14M);
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected)
        begin
            $display("error %s: expected %02h actual %02h", name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_sector(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        if (actual !== expected)
        begin
            $display("error %s: expected %04h actual %04h", name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    // Kind 0 none, 1 hdd_read, 2 hdd_write
    task automatic check_strobe(input string name, input logic [1:0] kind,
                                input int rd_n, input int wr_n);
        int exp_rd;
        int exp_wr;

        exp_rd = (kind == 2'd1) ? 1 : 0;
        exp_wr = (kind == 2'd2) ? 1 : 0;
        if (rd_n != exp_rd || wr_n != exp_wr)
        begin
            $display("error %s: expected read/write pulses %0d/%0d actual %0d/%0d",
                     name, exp_rd, exp_wr, rd_n, wr_n);
            test_ok = 1'b0;
        end
    endtask

    function automatic string op_label(input logic [15:0] op);
        case (op)
            OP_CPU_WR:    return "cpu_write";
            OP_CPU_RD:    return "cpu_read";
            OP_EXEC:      return "exec";
            OP_HOST_LOAD: return "host_load";
            OP_HOST_RD:   return "host_read";
            OP_RESET:     return "reset";
            OP_SECTOR:    return "sector";
            default:      return "unknown";
        endcase
    endfunction

    // ------------------------------------------------------------
    // One data file line
    // ------------------------------------------------------------
    task automatic run_test(input int idx);
        logic [15:0] op;
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] expv;
        string       name;

        op      = tdata[COLS*idx];
        addr    = tdata[COLS*idx+3];
        data    = tdata[COLS*idx+4];
        expv    = tdata[COLS*idx+5];
        name    = $sformatf("t%0d_%s", idx, op_label(op));
        test_ok = 1'b1;

        next_drive_point();
        hdd_mounted = tdata[COLS*idx+1][0];
        hdd_protect = tdata[COLS*idx+2][0];
        rd_pulses   = 0;
        wr_pulses   = 0;

        case (op)
            OP_CPU_WR:
            begin
                cpu_access(1'b0, addr[3:0], data[7:0]);
                check_strobe(name, 2'd0, rd_pulses, wr_pulses);
            end
            OP_CPU_RD:
            begin
                cpu_access(1'b1, addr[3:0], 8'h00);
                check_byte(name, expv[7:0], d_out);
                check_strobe(name, 2'd0, rd_pulses, wr_pulses);
            end
            OP_EXEC:
            begin
                cpu_access(1'b1, hdd_pkg::OFF_EXEC, 8'h00);
                check_byte(name, expv[7:0], d_out);
                check_strobe(name, data[1:0], rd_pulses, wr_pulses);
            end
            OP_HOST_LOAD:
            begin
                ram_addr = addr[BUF_AW-1:0];
                ram_di   = data[7:0];
                ram_we   = 1'b1;
                next_drive_point();
                ram_we   = 1'b0;
            end
            OP_HOST_RD:
            begin
                ram_addr = addr[BUF_AW-1:0];
                next_drive_point();     // Registered read
                @(negedge CLK_14M);
                check_byte(name, expv[7:0], ram_do);
            end
            OP_RESET:
            begin
                RESET = 1'b1;
                bus   = BUS_IDLE;
                repeat (2) next_drive_point();
                RESET = 1'b0;
                @(negedge CLK_14M);
                check_byte(name, expv[7:0], d_out);
            end
            OP_SECTOR:
            begin
                @(negedge CLK_14M);
                check_sector(name, expv, sector);
            end
            default:
            begin
                $display("%s: op code %0h in the data file is not known", name, op);
                test_ok = 1'b0;
            end
        endcase

        if (test_ok)
        begin
            pass_count++;
            $display("%s ok", name);
        end
        else
        begin
            err_count++;
            $display("%s failed", name);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial
    begin
        RESET       = 1'b1;
        bus         = BUS_IDLE;
        hdd_mounted = 1'b0;
        hdd_protect = 1'b0;
        ram_addr    = '0;
        ram_di      = 8'h00;
        ram_we      = 1'b0;

        $readmemh("test/hdd_testdata.txt", tdata);
        while (n_tests < MAX_TESTS && !$isunknown(tdata[COLS*n_tests]))
            n_tests++;
        loaded = 1'b1;

        repeat (2) @(posedge CLK_14M);
        #10 RESET = 1'b0;

        if (n_tests == 0)
        begin
            $display("no test lines could be read from test/hdd_testdata.txt");
            err_count++;
        end
        for (int i = 0; i < n_tests; i++)
            run_test(i);

        if (u_hdd_card.u_bus_fsm.u_assert.fails != 0)
        begin
            $display("bus FSM assertions failed %0d times", u_hdd_card.u_bus_fsm.u_assert.fails);
            err_count++;
        end

        $display("tests passed %0d, errors %0d", pass_count, err_count);
        if (err_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: test/hdd_testdata.txt
// op mounted protect offset/host_addr data expected, all hex
// op: 0 cpu write, 1 cpu read, 2 exec (data = strobe 0 none 1 read 2 write), 3 host load,
//     4 host read, 5 reset (expected d_out), 6 sector
5 0 0 0 00 FF
// Register round trip
0 1 0 2 03 00
0 1 0 3 70 00
0 1 0 4 34 00
0 1 0 5 12 00
0 1 0 6 5A 00
0 1 0 7 A5 00
1 1 0 2 00 03
1 1 0 3 00 70
1 1 0 4 00 34
1 1 0 5 00 12
1 1 0 6 00 5A
1 1 0 7 00 A5
6 1 0 0 00 A55A
0 1 0 1 80 00
1 1 0 1 00 80
2 1 0 0 0 00
1 1 0 1 00 00
// Read command
0 1 0 2 01 00
2 1 0 0 1 00
1 1 0 1 00 00
2 0 0 0 0 28
1 0 0 1 00 01
// Write command
0 1 1 2 02 00
2 0 0 0 0 28
2 1 1 0 0 2B
1 1 1 1 00 01
2 1 0 0 2 00
1 1 0 1 00 00
// Host to CPU streaming
3 1 0 000 C3 00
3 1 0 001 96 00
3 1 0 002 0F 00
3 1 0 003 E1 00
0 1 0 2 01 00
2 1 0 0 1 00
1 1 0 8 00 C3
1 1 0 8 00 96
1 1 0 8 00 0F
1 1 0 8 00 E1
// CPU to host streaming
0 1 0 2 02 00
0 1 0 8 A1 00
0 1 0 8 B2 00
0 1 0 8 C4 00
0 1 0 8 D8 00
4 1 0 000 00 A1
4 1 0 001 00 B2
4 1 0 002 00 C4
4 1 0 003 00 D8
2 1 0 0 2 00
// Mid-run reset, buffer contents survive
5 1 0 0 00 FF
1 1 0 2 00 00
1 1 0 7 00 00
1 1 0 1 00 00
6 1 0 0 00 0000
4 1 0 000 00 A1
1 1 0 8 00 A1

// File: sim.f
source/hdd_pkg.sv
source/hdd_bus_fsm.sv
source/hdd_sec_counter.sv
source/hdd_sector_buf.sv
source/hdd_regs.sv
source/hdd_card.sv
test/hdd_card_assert.sv
test/hdd_card_tb.sv
